// ==== hw/soc_pkg.sv ====
package soc_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and I/O widths
  ////////////////////////////////////////////////////////////

  // One bus word
  localparam int DATA_WIDTH = 32;
  // Byte address of an access
  localparam int ADDR_WIDTH = 16;
  // LED register and switch bank
  localparam int LED_WIDTH  = 10;

  ////////////////////////////////////////////////////////////
  // I/O address map
  ////////////////////////////////////////////////////////////

  // LEDs and switches
  localparam logic [ADDR_WIDTH-1:0] ADDR_LED  = 16'hC000;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SW   = 16'hC001;
  // UART registers, low two bits pick the register
  localparam logic [ADDR_WIDTH-1:0] ADDR_DBUF = 16'hC004;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SREG = 16'hC005;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DBL  = 16'hC006;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DBH  = 16'hC007;

  ////////////////////////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////////////////////////

  // Decode result of one access
  typedef enum logic [2:0] {MEM, LED, SW, UART, NONE} mmio_target_e;

  // UART register select, same order as the address low bits
  typedef enum logic [1:0] {DBUF = 2'd0, SREG = 2'd1, DBL = 2'd2, DBH = 2'd3} uart_reg_e;

  // Frame position of the transmitter and the receiver
  typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;

endpackage

// ==== hw/bus_bridge.sv ====
module bus_bridge (
  input  logic                           clk,
  input  logic                           rst_n,
  // External four-phase port
  input  logic                           req_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [3:0]                     we_i,
  input  logic                           re_i,
  input  logic                           ldcr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                           ack_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o,
  // Internal access strobe and fields
  output logic                           acc_o,
  output logic [soc_pkg::ADDR_WIDTH-1:0] acc_addr_o,
  output logic [3:0]                     acc_we_o,
  output logic                           acc_re_o,
  output logic                           acc_ldcr_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] acc_wdata_o,
  input  logic [soc_pkg::DATA_WIDTH-1:0] rd_data_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {BR_IDLE, BR_ACCESS, BR_WAIT, BR_ACK} bridge_state_e;

  bridge_state_e state;

  // Strobe lasts exactly the access state
  assign acc_o = (state == BR_ACCESS);

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= BR_IDLE;
      ack_o      <= 1'b0;
      acc_we_o   <= '0;
      acc_re_o   <= 1'b0;
      acc_ldcr_o <= 1'b0;
    end else begin
      case (state)
        // Edge 1, new request captured
        BR_IDLE: begin
          if (req_i) begin
            state      <= BR_ACCESS;
            acc_we_o   <= we_i;
            acc_re_o   <= re_i;
            acc_ldcr_o <= ldcr_i;
          end
        end
        // Edge 2, targets act on the strobe
        BR_ACCESS: state <= BR_WAIT;
        // Edge 3, read data taken and ack raised
        BR_WAIT: begin
          state <= BR_ACK;
          ack_o <= 1'b1;
        end
        // Hold until master lets go
        BR_ACK: begin
          if (!req_i) begin
            state <= BR_IDLE;
            ack_o <= 1'b0;
          end
        end
        default: state <= BR_IDLE;
      endcase
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (state == BR_IDLE && req_i) begin
      acc_addr_o  <= addr_i;
      acc_wdata_o <= wdata_i;
    end
    if (state == BR_WAIT)
      rdata_o <= rd_data_i;
  end

endmodule

// ==== hw/addr_map.sv ====
module addr_map #(
  parameter int IMEM_DEPTH = 4,
  parameter int DMEM_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // Access from the bridge
  input  logic                           acc_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [3:0]                     we_i,
  input  logic                           re_i,
  input  logic                           ldcr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [soc_pkg::DATA_WIDTH-1:0] rd_data_o,
  // Memory side
  output logic [3:0]                     mem_we_o,
  output logic [DMEM_DEPTH-1:0]          mem_addr_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] mem_wdata_o,
  input  logic [soc_pkg::DATA_WIDTH-1:0] mem_rdata_i,
  output logic [IMEM_DEPTH-1:0]          imem_daddr_o,
  input  logic [soc_pkg::DATA_WIDTH-1:0] imem_data_i,
  // UART side
  output logic                           uart_cs_o,
  output logic                           uart_wr_o,
  output soc_pkg::uart_reg_e             uart_sel_o,
  output logic [7:0]                     uart_wdata_o,
  input  logic [7:0]                     uart_rdata_i,
  // I/O side
  input  logic [soc_pkg::LED_WIDTH-1:0]  sw_i,
  output logic [soc_pkg::LED_WIDTH-1:0]  ledr_o
);
  import soc_pkg::*;

  mmio_target_e         target;
  mmio_target_e         target_q;
  logic                 ldcr_q;
  logic                 any_we;
  logic [LED_WIDTH-1:0] led_q;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Physical memory when top three bits are clear
    if (addr_i[ADDR_WIDTH-1 -: 3] == 3'b000) begin
      target = MEM;
    end else begin
      case (addr_i)
        ADDR_LED:  target = LED;
        ADDR_SW:   target = SW;
        ADDR_DBUF,
        ADDR_SREG,
        ADDR_DBL,
        ADDR_DBH:  target = UART;
        default:   target = NONE;
      endcase
    end
  end

  assign any_we = |we_i;

  // Data memory, lanes only on the strobe
  assign mem_we_o     = (acc_i && target == MEM) ? we_i : 4'b0000;
  assign mem_addr_o   = addr_i[DMEM_DEPTH+1:2];
  // Big-endian byte order in the array
  assign mem_wdata_o  = {wdata_i[7:0], wdata_i[15:8], wdata_i[23:16], wdata_i[31:24]};
  // Word index for instruction data reads
  assign imem_daddr_o = addr_i[IMEM_DEPTH+1:2];

  // UART select follows the address low bits
  assign uart_cs_o    = acc_i && target == UART && (any_we || re_i);
  assign uart_wr_o    = any_we;
  assign uart_sel_o   = uart_reg_e'(addr_i[1:0]);
  assign uart_wdata_o = wdata_i[7:0];

  ////////////////////////////////////////////////////////////
  // LED register and read target
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q    <= '0;
      target_q <= NONE;
      ldcr_q   <= 1'b0;
    end else if (acc_i) begin
      // Any lane counts as a write
      if (target == LED && any_we)
        led_q <= wdata_i[LED_WIDTH-1:0];
      // Source for the read one cycle later
      target_q <= target;
      ldcr_q   <= ldcr_i;
    end
  end

  assign ledr_o = led_q;

  // Read mux, memories already registered
  always_comb begin
    case (target_q)
      MEM:     rd_data_o = ldcr_q ? imem_data_i : mem_rdata_i;
      SW:      rd_data_o = {{(DATA_WIDTH-LED_WIDTH){1'b0}}, sw_i};
      UART:    rd_data_o = {{(DATA_WIDTH-8){1'b0}}, uart_rdata_i};
      // LED readback and unmapped space
      default: rd_data_o = '0;
    endcase
  end

endmodule

// ==== hw/data_mem.sv ====
module data_mem #(
  parameter int DMEM_DEPTH = 8
) (
  input  logic                           clk,
  input  logic [3:0]                     we_i,
  input  logic [DMEM_DEPTH-1:0]          addr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [soc_pkg::DATA_WIDTH-1:0] rdata_o
);
  import soc_pkg::*;

  localparam int LANES = DATA_WIDTH / 8;

  // Word array, one entry per word index
  logic [DATA_WIDTH-1:0] mem [2**DMEM_DEPTH];

  ////////////////////////////////////////////////////////////
  // Byte lane writes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < LANES; lane++) begin
      // Each lane written on its own
      if (we_i[lane])
        mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
    end
  end

  // Registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata_o <= mem[addr_i];
  end

endmodule

// ==== hw/inst_mem.sv ====
module inst_mem #(
  parameter int IMEM_DEPTH = 4
) (
  input  logic                           clk,
  input  logic [IMEM_DEPTH-1:0]          addr_i,
  input  logic [IMEM_DEPTH-1:0]          daddr_i,
  output logic [soc_pkg::DATA_WIDTH-1:0] inst_o,
  output logic [soc_pkg::DATA_WIDTH-1:0] data_o
);
  import soc_pkg::*;

  // Shared word array
  logic [DATA_WIDTH-1:0] mem [2**IMEM_DEPTH];

  // Program image
  initial begin
    $readmemh("bench/imem.hex", mem);
  end

  ////////////////////////////////////////////////////////////
  // Two read ports
  ////////////////////////////////////////////////////////////

  // Fetch side
  always_ff @(posedge clk) begin
    inst_o <= mem[addr_i];
  end

  // Data side, used for ldcr reads
  always_ff @(posedge clk) begin
    data_o <= mem[daddr_i];
  end

endmodule

// ==== hw/uart_port.sv ====
module uart_port #(
  parameter int BAUD_RESET = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  // Register access
  input  logic               cs_i,
  input  logic               wr_i,
  input  soc_pkg::uart_reg_e sel_i,
  input  logic [7:0]         wdata_i,
  output logic [7:0]         rdata_o,
  // Serial lines
  input  logic               rx_i,
  output logic               tx_o
);
  import soc_pkg::*;

  logic [15:0] divisor;
  // Transmitter
  uart_state_e tx_state;
  logic [15:0] tx_cnt;
  logic [2:0]  tx_bit;
  logic [7:0]  tx_shift;
  logic        tx_tick;
  logic        tx_load;
  logic        tx_ready;
  // Receiver
  logic        rx_meta;
  logic        rx_sync;
  uart_state_e rx_state;
  logic [15:0] rx_cnt;
  logic [2:0]  rx_bit;
  logic [7:0]  rx_shift;
  logic [7:0]  rx_buf;
  logic        rx_full;
  logic        rx_tick;
  logic        rx_mid;
  logic        rx_take;

  assign tx_ready = (tx_state == IDLE);
  // Buffer write while busy is dropped
  assign tx_load  = cs_i && wr_i && sel_i == DBUF && tx_ready;
  assign tx_tick  = (tx_cnt == divisor - 16'd1);
  assign rx_tick  = (rx_cnt == divisor - 16'd1);
  assign rx_mid   = (rx_cnt == {1'b0, divisor[15:1]});
  assign rx_take  = cs_i && !wr_i && sel_i == DBUF;

  // Baud divisor, written by halves
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      divisor <= 16'(BAUD_RESET);
    else if (cs_i && wr_i && sel_i == DBL)
      divisor[7:0] <= wdata_i;
    else if (cs_i && wr_i && sel_i == DBH)
      divisor[15:8] <= wdata_i;
  end

  ////////////////////////////////////////////////////////////
  // Transmitter, 8N1 with LSB first
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx_shift <= '0;
      tx_o     <= 1'b1;
    end else begin
      tx_cnt <= tx_tick ? 16'd0 : tx_cnt + 16'd1;
      case (tx_state)
        IDLE: begin
          tx_cnt <= '0;
          // Start bit goes out right away
          if (tx_load) begin
            tx_state <= START;
            tx_shift <= wdata_i;
            tx_o     <= 1'b0;
          end
        end
        START: begin
          if (tx_tick) begin
            tx_state <= DATA;
            tx_bit   <= '0;
            tx_o     <= tx_shift[0];
            tx_shift <= tx_shift >> 1;
          end
        end
        DATA: begin
          if (tx_tick) begin
            if (tx_bit == 3'd7) begin
              tx_state <= STOP;
              tx_o     <= 1'b1;
            end else begin
              tx_bit   <= tx_bit + 3'd1;
              tx_o     <= tx_shift[0];
              tx_shift <= tx_shift >> 1;
            end
          end
        end
        STOP: if (tx_tick) tx_state <= IDLE;
        default: tx_state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Receiver
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_state <= IDLE;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      rx_shift <= '0;
      rx_buf   <= '0;
      rx_full  <= 1'b0;
    end else begin
      // Two-flop synchronizer
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_cnt  <= rx_tick ? 16'd0 : rx_cnt + 16'd1;
      // Reading the buffer empties it
      if (rx_take)
        rx_full <= 1'b0;
      case (rx_state)
        IDLE: begin
          rx_cnt <= '0;
          if (!rx_sync)
            rx_state <= START;
        end
        // Half a bit in, start bit must still be low
        START: begin
          if (rx_mid) begin
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_state <= rx_sync ? IDLE : DATA;
          end
        end
        DATA: begin
          if (rx_tick) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
            rx_bit   <= rx_bit + 3'd1;
            if (rx_bit == 3'd7)
              rx_state <= STOP;
          end
        end
        // Valid stop bit loads the buffer, overwriting an unread byte
        STOP: begin
          if (rx_tick) begin
            rx_state <= IDLE;
            if (rx_sync) begin
              rx_buf  <= rx_shift;
              rx_full <= 1'b1;
            end
          end
        end
        default: rx_state <= IDLE;
      endcase
    end
  end

  // Read data registered at the strobe edge
  always_ff @(posedge clk) begin
    if (cs_i && !wr_i) begin
      case (sel_i)
        DBUF:    rdata_o <= rx_buf;
        SREG:    rdata_o <= {6'b0, rx_full, tx_ready};
        DBL:     rdata_o <= divisor[7:0];
        default: rdata_o <= divisor[15:8];
      endcase
    end
  end

endmodule

// ==== hw/mmio_soc.sv ====
module mmio_soc #(
  parameter int IMEM_DEPTH = 4,
  parameter int DMEM_DEPTH = 8,
  parameter int BAUD_RESET = 8
) (
  input  logic                             clk,
  input  logic                             rst_n,
  // External bus port
  input  logic                             req_i,
  input  logic [soc_pkg::ADDR_WIDTH-1:0]   addr_i,
  input  logic [3:0]                       we_i,
  input  logic                             re_i,
  input  logic                             ldcr_i,
  input  logic [soc_pkg::DATA_WIDTH-1:0]   wdata_i,
  output logic                             ack_o,
  output logic [soc_pkg::DATA_WIDTH-1:0]   rdata_o,
  // Instruction fetch port, word index
  input  logic [soc_pkg::ADDR_WIDTH-1:0]   fetch_addr_i,
  output logic [soc_pkg::DATA_WIDTH-1:0]   inst_o,
  // Board I/O
  input  logic [soc_pkg::LED_WIDTH-1:0]    sw_i,
  output logic [soc_pkg::LED_WIDTH-1:0]    ledr_o,
  input  logic                             rx_i,
  output logic                             tx_o
);
  import soc_pkg::*;

  // Bridge to address map
  logic                  acc;
  logic [ADDR_WIDTH-1:0] acc_addr;
  logic [3:0]            acc_we;
  logic                  acc_re;
  logic                  acc_ldcr;
  logic [DATA_WIDTH-1:0] acc_wdata;
  logic [DATA_WIDTH-1:0] rd_data;

  // Memories
  logic [3:0]            mem_we;
  logic [DMEM_DEPTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0] mem_wdata;
  logic [DATA_WIDTH-1:0] mem_rdata;
  logic [IMEM_DEPTH-1:0] imem_daddr;
  logic [DATA_WIDTH-1:0] imem_data;

  // UART
  logic      uart_cs;
  logic      uart_wr;
  uart_reg_e uart_sel;
  logic [7:0] uart_wdata;
  logic [7:0] uart_rdata;

  bus_bridge i_bus_bridge (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .we_i         (we_i),
    .re_i         (re_i),
    .ldcr_i       (ldcr_i),
    .wdata_i      (wdata_i),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o),
    .acc_o        (acc),
    .acc_addr_o   (acc_addr),
    .acc_we_o     (acc_we),
    .acc_re_o     (acc_re),
    .acc_ldcr_o   (acc_ldcr),
    .acc_wdata_o  (acc_wdata),
    .rd_data_i    (rd_data)
  );

  addr_map #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH)
  ) i_addr_map (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc_i        (acc),
    .addr_i       (acc_addr),
    .we_i         (acc_we),
    .re_i         (acc_re),
    .ldcr_i       (acc_ldcr),
    .wdata_i      (acc_wdata),
    .rd_data_o    (rd_data),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .imem_daddr_o (imem_daddr),
    .imem_data_i  (imem_data),
    .uart_cs_o    (uart_cs),
    .uart_wr_o    (uart_wr),
    .uart_sel_o   (uart_sel),
    .uart_wdata_o (uart_wdata),
    .uart_rdata_i (uart_rdata),
    .sw_i         (sw_i),
    .ledr_o       (ledr_o)
  );

  data_mem #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) i_data_mem (
    .clk     (clk),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  // Fetch address truncated to the array size
  inst_mem #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) i_inst_mem (
    .clk     (clk),
    .addr_i  (fetch_addr_i[IMEM_DEPTH-1:0]),
    .daddr_i (imem_daddr),
    .inst_o  (inst_o),
    .data_o  (imem_data)
  );

  uart_port #(
    .BAUD_RESET (BAUD_RESET)
  ) i_uart_port (
    .clk     (clk),
    .rst_n   (rst_n),
    .cs_i    (uart_cs),
    .wr_i    (uart_wr),
    .sel_i   (uart_sel),
    .wdata_i (uart_wdata),
    .rdata_o (uart_rdata),
    .rx_i    (rx_i),
    .tx_o    (tx_o)
  );

endmodule

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference memories
////////////////////////////////////////////////////////////

// Data memory as the array holds it, big-endian
logic [DATA_WIDTH-1:0] dmem_ref [2**DMEM_DEPTH];
// Instruction image, same file as the DUT
logic [DATA_WIDTH-1:0] imem_ref [2**IMEM_DEPTH];

task automatic load_image();
  $readmemh("bench/imem.hex", imem_ref);
endtask

// Lane 0 takes the first byte of the bus word
task automatic ref_write(input logic [ADDR_WIDTH-1:0] addr, input logic [3:0] we_mask,
                         input logic [DATA_WIDTH-1:0] data);
  logic [DMEM_DEPTH-1:0] widx;
  logic [DATA_WIDTH-1:0] word;
  widx = addr[DMEM_DEPTH+1:2];
  word = dmem_ref[widx];
  if (we_mask[0])
    word[7:0] = data[31:24];
  if (we_mask[1])
    word[15:8] = data[23:16];
  if (we_mask[2])
    word[23:16] = data[15:8];
  if (we_mask[3])
    word[31:24] = data[7:0];
  dmem_ref[widx] = word;
endtask

////////////////////////////////////////////////////////////
// Expected values
////////////////////////////////////////////////////////////

// UART registers are checked on their own, LED has no readback
function automatic logic [DATA_WIDTH-1:0] exp_read(input logic [ADDR_WIDTH-1:0] addr,
                                                   input logic ldcr_flag,
                                                   input logic [LED_WIDTH-1:0] sw_val);
  logic [DMEM_DEPTH-1:0] widx;
  logic [IMEM_DEPTH-1:0] iidx;
  logic [DATA_WIDTH-1:0] word;
  // Word index is the byte address over four, truncated
  widx = addr[DMEM_DEPTH+1:2];
  iidx = addr[IMEM_DEPTH+1:2];
  if (addr[ADDR_WIDTH-1 -: 3] == 3'b000)
    word = ldcr_flag ? imem_ref[iidx] : dmem_ref[widx];
  else if (addr == ADDR_SW)
    word = {{(DATA_WIDTH-LED_WIDTH){1'b0}}, sw_val};
  else
    word = '0;
  return word;
endfunction

// Fetch port takes a word index
function automatic logic [DATA_WIDTH-1:0] exp_fetch(input logic [ADDR_WIDTH-1:0] widx);
  return imem_ref[widx[IMEM_DEPTH-1:0]];
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp_val,
                          input logic [DATA_WIDTH-1:0] act_val);
  if (act_val !== exp_val) begin
    $display("error %s: expected %h, actual %h", name, exp_val, act_val);
    stop_run();
  end
endtask

task automatic check_led(input string name, input logic [LED_WIDTH-1:0] exp_val,
                         input logic [LED_WIDTH-1:0] act_val);
  if (act_val !== exp_val) begin
    $display("error %s: expected %h, actual %h", name, exp_val, act_val);
    stop_run();
  end
endtask

task automatic check_byte(input string name, input logic [7:0] exp_val,
                          input logic [7:0] act_val);
  if (act_val !== exp_val) begin
    $display("error %s: expected %h, actual %h", name, exp_val, act_val);
    stop_run();
  end
endtask

// Handshake edge counts
task automatic check_latency(input string name, input int exp_val, input int act_val);
  if (act_val != exp_val) begin
    $display("error %s: expected %0d edges, actual %0d edges", name, exp_val, act_val);
    stop_run();
  end
endtask

`endif

// ==== bench/tb_mmio_soc.sv ====
module tb_mmio_soc;
  timeunit 1ns;
  timeprecision 100ps;

  import soc_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 31732;
  localparam int ACK_TIMEOUT  = 20;
  localparam int POLL_LIMIT   = 400;
  localparam int IMEM_DEPTH   = 4;
  localparam int DMEM_DEPTH   = 8;
  localparam int BAUD_RESET   = 8;
  // Words under test, matches the 5-bit random index
  localparam int TEST_WORDS   = 32;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic [ADDR_WIDTH-1:0] addr;
  logic [3:0]            we;
  logic                  re;
  logic                  ldcr;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  ack;
  logic [DATA_WIDTH-1:0] rdata;
  logic [ADDR_WIDTH-1:0] fetch_addr;
  logic [DATA_WIDTH-1:0] inst;
  logic [LED_WIDTH-1:0]  sw;
  logic [LED_WIDTH-1:0]  ledr;
  // TX looped back to RX
  logic                  serial;

  // Handoff to the read checker
  event                  chk_ev;
  string                 chk_name;
  logic [ADDR_WIDTH-1:0] chk_addr;
  logic                  chk_ldcr;
  logic [LED_WIDTH-1:0]  chk_sw;
  logic [DATA_WIDTH-1:0] chk_data;

  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
  endtask

  `include "tb_model.svh"

  mmio_soc #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH),
    .BAUD_RESET (BAUD_RESET)
  ) i_mmio_soc (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .addr_i       (addr),
    .we_i         (we),
    .re_i         (re),
    .ldcr_i       (ldcr),
    .wdata_i      (wdata),
    .ack_o        (ack),
    .rdata_o      (rdata),
    .fetch_addr_i (fetch_addr),
    .inst_o       (inst),
    .sw_i         (sw),
    .ledr_o       (ledr),
    .rx_i         (serial),
    .tx_o         (serial)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Bus reads against the reference model
  always @(chk_ev) begin
    check_word(chk_name, exp_read(chk_addr, chk_ldcr, chk_sw), chk_data);
  end

  ////////////////////////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////////////////////////

  // Called 1 ns after an edge, returns at the same point
  task automatic run_handshake(input string name, output logic [DATA_WIDTH-1:0] data);
    int edges;
    edges = 0;
    req   = 1'b1;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack && edges < ACK_TIMEOUT);
    if (!ack)
      report_problem($sformatf("timeout: %s, ack did not rise within %0d cycles",
                               name, ACK_TIMEOUT));
    check_latency({name, " ack rise"}, 3, edges);
    data  = rdata;
    req   = 1'b0;
    we    = '0;
    re    = 1'b0;
    ldcr  = 1'b0;
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (ack && edges < ACK_TIMEOUT);
    if (ack)
      report_problem($sformatf("timeout: %s, ack did not fall within %0d cycles",
                               name, ACK_TIMEOUT));
    check_latency({name, " ack fall"}, 1, edges);
  endtask

  task automatic bus_write(input string name, input logic [ADDR_WIDTH-1:0] a,
                           input logic [3:0] lanes, input logic [DATA_WIDTH-1:0] d);
    logic [DATA_WIDTH-1:0] unused_data;
    addr  = a;
    we    = lanes;
    re    = 1'b0;
    ldcr  = 1'b0;
    wdata = d;
    run_handshake(name, unused_data);
  endtask

  task automatic bus_read(input string name, input logic [ADDR_WIDTH-1:0] a,
                          input logic ld, output logic [DATA_WIDTH-1:0] d);
    addr  = a;
    we    = '0;
    re    = 1'b1;
    ldcr  = ld;
    wdata = '0;
    run_handshake(name, d);
  endtask

  task automatic read_and_check(input string name, input logic [ADDR_WIDTH-1:0] a,
                                input logic ld);
    logic [DATA_WIDTH-1:0] d;
    bus_read(name, a, ld, d);
    chk_name = name;
    chk_addr = a;
    chk_ldcr = ld;
    // Switch value seen by this read
    chk_sw   = sw;
    chk_data = d;
    -> chk_ev;
  endtask

  // Repeated status reads until a masked bit is set
  task automatic poll_status(input string name, input logic [7:0] mask);
    logic [DATA_WIDTH-1:0] d;
    int polls;
    polls = 0;
    do begin
      bus_read(name, ADDR_SREG, 1'b0, d);
      polls++;
    end while ((d[7:0] & mask) == 8'h00 && polls < POLL_LIMIT);
    if ((d[7:0] & mask) == 8'h00)
      report_problem($sformatf("timeout: %s, status bit never set after %0d polls",
                               name, POLL_LIMIT));
  endtask

  task automatic probe_unmapped(input logic [ADDR_WIDTH-1:0] a);
    bus_write("unmapped write", a, 4'hF, $urandom());
    read_and_check("unmapped read", a, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    int                    i;
    int unsigned           seed_dummy;
    logic [DATA_WIDTH-1:0] d;
    logic [ADDR_WIDTH-1:0] a;
    logic [3:0]            lanes;
    logic [7:0]            b;
    logic [LED_WIDTH-1:0]  led_exp;
    seed_dummy = $urandom(SEED);
    rst_n      = 1'b0;
    req        = 1'b0;
    addr       = '0;
    we         = '0;
    re         = 1'b0;
    ldcr       = 1'b0;
    wdata      = '0;
    fetch_addr = '0;
    sw         = 10'($urandom());
    load_image();

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    if (ack !== 1'b0)
      report_problem("ack is high during reset");
    if (serial !== 1'b1)
      report_problem("UART TX is not idle high during reset");
    check_led("reset led", '0, ledr);
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    if (ack !== 1'b0)
      report_problem("ack is high after reset");

    // Data memory, full words first so every lane is known
    for (i = 0; i < TEST_WORDS; i++) begin
      a = 16'(i * 4);
      d = $urandom();
      bus_write("dmem fill", a, 4'hF, d);
      ref_write(a, 4'hF, d);
    end
    for (i = 0; i < 64; i++) begin
      a     = {9'b0, 5'($urandom()), 2'b00};
      lanes = 4'($urandom());
      d     = $urandom();
      bus_write("dmem lane write", a, lanes, d);
      ref_write(a, lanes, d);
    end
    for (i = 0; i < TEST_WORDS; i++)
      read_and_check("dmem read", 16'(i * 4), 1'b0);

    // Instruction memory by ldcr, then aliased addresses
    for (i = 0; i < 2**IMEM_DEPTH; i++)
      read_and_check("imem data read", 16'(i * 4), 1'b1);
    for (i = 0; i < 8; i++)
      read_and_check("imem alias read", {3'b000, 11'($urandom()), 2'b00}, 1'b1);
    // Fetch port, one-cycle registered read
    for (i = 0; i < 16; i++) begin
      fetch_addr = 16'($urandom());
      @(posedge clk);
      #1;
      check_word("fetch read", exp_fetch(fetch_addr), inst);
    end

    // LED register and switches
    d       = $urandom();
    led_exp = d[LED_WIDTH-1:0];
    bus_write("led write", ADDR_LED, 4'b0100, d);
    check_led("led write", led_exp, ledr);
    d = $urandom();
    bus_write("led hold write", 16'h0000, 4'hF, d);
    ref_write(16'h0000, 4'hF, d);
    read_and_check("led hold read", 16'h0000, 1'b0);
    read_and_check("switch read", ADDR_SW, 1'b0);
    check_led("led hold", led_exp, ledr);
    sw = 10'($urandom());
    read_and_check("switch read new", ADDR_SW, 1'b0);

    ////////////////////////////////////////////////////////////
    // UART loopback
    ////////////////////////////////////////////////////////////
    bus_write("baud low", ADDR_DBL, 4'b0001, 32'h0000_000A);
    bus_write("baud high", ADDR_DBH, 4'b0001, 32'h0000_0000);
    bus_read("baud readback", ADDR_DBL, 1'b0, d);
    check_byte("baud readback", 8'h0A, d[7:0]);
    for (i = 0; i < 8; i++) begin
      b = 8'($urandom());
      poll_status("uart tx ready", 8'h01);
      bus_write("uart send", ADDR_DBUF, 4'b0001, {24'b0, b});
      poll_status("uart rx full", 8'h02);
      bus_read("uart receive", ADDR_DBUF, 1'b0, d);
      check_byte("uart receive", b, d[7:0]);
      // Receive full drops once the buffer is read
      bus_read("uart status", ADDR_SREG, 1'b0, d);
      check_byte("uart rx full clear", 8'h00, d[7:0] & 8'h02);
    end

    // Unmapped I/O and unmapped high regions
    probe_unmapped(16'hC002);
    probe_unmapped(16'hC003);
    probe_unmapped(16'hC008);
    probe_unmapped(16'hC0FF);
    probe_unmapped(16'h2000);
    probe_unmapped(16'h4000);
    probe_unmapped(16'h8000);
    probe_unmapped(16'hE000);
    check_led("led after unmapped", led_exp, ledr);
    for (i = 0; i < TEST_WORDS; i++)
      read_and_check("dmem after unmapped", 16'(i * 4), 1'b0);

    // Idle cycle, last read compared before the summary
    @(posedge clk);
    #1;
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== bench/imem.hex ====
// One 32-bit instruction word per line, word index 0 to 15 in order
0AF50CF3
1AE51CE3
2AD52CD3
3AC53CC3
4AB54CB3
5AA55CA3
6A956C93
7A857C83
8A758C73
9A659C63
AA55AC53
BA45BC43
CA35CC33
DA25DC23
EA15EC13
FA05FC03

// ==== src.f ====
+incdir+bench
hw/soc_pkg.sv
hw/bus_bridge.sv
hw/addr_map.sv
hw/data_mem.sv
hw/inst_mem.sv
hw/uart_port.sv
hw/mmio_soc.sv
bench/tb_mmio_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, then decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timescale 1ns/100ps -f src.f --top-module tb_mmio_soc \
  -Mdir obj_dir -o tb_mmio_soc_sim && ./obj_dir/tb_mmio_soc_sim 2>&1 | tee sim.log
grep -sqx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
